// File: include/st_io_map.svh
// ======================================
// st io and rom map
// base addresses and match widths of the
// decoded windows, a width counts the low
// address bits that the match ignores
// ======================================
`ifndef ST_IO_MAP_SVH
`define ST_IO_MAP_SVH

// top address byte of the io page
localparam logic [7:0] IO_PAGE = 8'hff;

// io windows as offsets inside the io page
localparam logic [15:0] IO_MMU_BASE = 16'h8000;
localparam int IO_MMU_W = 1;
localparam logic [15:0] IO_VIDEO_BASE = 16'h8200;
localparam int IO_VIDEO_W = 7;
localparam logic [15:0] IO_DMA_BASE = 16'h8600;
localparam int IO_DMA_W = 4;
localparam logic [15:0] IO_PSG_BASE = 16'h8800;
localparam int IO_PSG_W = 8;
localparam logic [15:0] IO_STE_SND_BASE = 16'h8900;
localparam int IO_STE_SND_W = 6;
localparam logic [15:0] IO_BLITTER_BASE = 16'h8a00;
localparam int IO_BLITTER_W = 8;
localparam logic [15:0] IO_STE_JOY_BASE = 16'h9200;
localparam int IO_STE_JOY_W = 6;
localparam logic [15:0] IO_MFP_BASE = 16'hfa00;
localparam int IO_MFP_W = 6;
localparam logic [15:0] IO_ACIA_BASE = 16'hfc00;
localparam int IO_ACIA_W = 8;

// rom mirror of the reset vectors at address 0
localparam int LOW_ROM_W = 3;
// 256k tos at e00000
localparam logic [23:0] TOS256_BASE = 24'he00000;
localparam int TOS256_W = 18;
// 192k tos split in a 128k and a 64k area
localparam logic [23:0] TOS192_LO_BASE = 24'hfc0000;
localparam int TOS192_LO_W = 17;
localparam logic [23:0] TOS192_HI_BASE = 24'hfe0000;
localparam int TOS192_HI_W = 16;
// 128k cartridge at fa0000
localparam logic [23:0] CART_BASE = 24'hfa0000;
localparam int CART_W = 17;

`endif

// File: logic/st_glue_pkg.sv
// ======================================
// st_glue shared definitions
// bus types, slot numbers, peripheral select
// codes, interrupt levels and vectors
// ======================================
package st_glue_pkg;

	// 68000 byte address, 24 bit
	typedef logic [23:0] st_addr_t;
	// cpu data bus word
	typedef logic [15:0] word_t;
	// one of four 8 MHz bus slots
	typedef logic [1:0] slot_t;
	// 68000 function code
	typedef logic [2:0] fc_t;
	// active low interrupt priority level
	typedef logic [2:0] ipl_t;
	typedef logic [7:0] vector_t;

	localparam slot_t SLOT_VIDEO = 2'd0;
	localparam slot_t SLOT_CPU = 2'd1;
	// only used in fast mode
	localparam slot_t SLOT_CPU2 = 2'd3;

	// cpu space cycle, interrupt acknowledge
	localparam fc_t FC_IACK = 3'd7;

	// ipl[0] stays high on the st so only even levels show up
	localparam ipl_t IPL_NONE = 3'd7;
	localparam ipl_t IPL_MFP = 3'd1;
	localparam ipl_t IPL_VBI = 3'd3;
	localparam ipl_t IPL_HBI = 3'd5;

	localparam vector_t VEC_VBI = 8'h1c;
	localparam vector_t VEC_HBI = 8'h1a;

	// installed ram, decides which windows above 4 MB exist
	typedef enum logic [2:0] {
		MEM_512K,
		MEM_1M,
		MEM_2M,
		MEM_4M,
		MEM_8M,
		MEM_14M
	} mem_size_t;

	typedef enum logic [3:0] {
		DEV_NONE,
		DEV_MMU,
		DEV_VIDEO,
		DEV_DMA,
		DEV_PSG,
		DEV_ACIA,
		DEV_MFP,
		DEV_BLITTER,
		DEV_STE_JOY,
		DEV_STE_SND
	} dev_t;

	// missing dtack counter
	localparam int TIMEOUT_W = 4;
	localparam logic [TIMEOUT_W-1:0] TIMEOUT_MAX = 4'd15;

	`include "st_io_map.svh"

endpackage

// File: logic/cpu_bus_if.sv
// ======================================
// cpu bus
// latched 68000 bus signals together with
// the cpu slot flag from the slot counter
// ======================================
interface cpu_bus_if;
	import st_glue_pkg::*;

	logic as;
	st_addr_t addr;
	logic rw;
	fc_t fc;
	// high while the cpu owns the current slot
	logic cpu_cycle;

	// offset of the address inside a 64k page
	function automatic word_t io_offset();
		return addr[15:0];
	endfunction

	modport slot (
		output cpu_cycle
	);

	modport decode (
		input as, addr, rw, cpu_cycle,
		import io_offset
	);

	modport irq (
		input as, addr, fc, cpu_cycle
	);

endinterface

// File: logic/bus_slot.sv
// ======================================
// bus slot sequencer
// four slot bus cycle shared between video
// and the cpu
// ======================================
module bus_slot (
	input logic clk_8,
	input logic pll_locked,
	input logic cfg_fast_cpu,
	cpu_bus_if.slot bus,
	output st_glue_pkg::slot_t bus_cycle,
	output logic video_cycle
);
	import st_glue_pkg::*;

	slot_t slot;
	logic cpu_slot;
	logic cpu2_slot;

	// free running, starts at the video slot once the pll has locked
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			slot <= SLOT_VIDEO;
		end else begin
			// wraps from 3 back to 0
			slot <= slot + 2'd1;
		end
	end

	// normal cpu slot
	assign cpu_slot = (slot == SLOT_CPU);

	// second cpu slot gives the 16 MHz like fast mode
	assign cpu2_slot = cfg_fast_cpu && (slot == SLOT_CPU2);

	assign bus.cpu_cycle = cpu_slot || cpu2_slot;

	// video fetch owns slot 0 only
	assign video_cycle = (slot == SLOT_VIDEO);

	// slot 2 stays unused by both masters
	assign bus_cycle = slot;

endmodule

// File: logic/addr_decode.sv
// ======================================
// address decoder
// cpu addresses to memory strobes,
// peripheral select and dtack
// ======================================
module addr_decode (
	cpu_bus_if.decode bus,
	input logic br,
	input st_glue_pkg::mem_size_t cfg_mem,
	input logic cfg_ste,
	input logic cfg_blitter,
	input logic iack_dtack,
	output st_glue_pkg::dev_t dev_sel,
	output logic mem_rd,
	output logic mem_wr,
	output logic dtack
);
	import st_glue_pkg::*;

	logic cpu_acc;
	logic low_rom;
	logic ram;
	logic tos;
	logic cart;
	logic mem_hit;
	logic io_sel;
	word_t io_off;

	// compare all address bits above the ignored low ones
	function automatic logic mem_match(st_addr_t a, st_addr_t base, int unsigned w);
		return (a >> w) == (base >> w);
	endfunction

	function automatic logic io_match(word_t off, word_t base, int unsigned w);
		return (off >> w) == (base >> w);
	endfunction

	// cpu has a valid cycle in its own slot
	assign cpu_acc = bus.cpu_cycle && bus.as;

	// reset vectors come from rom, not ram
	assign low_rom = mem_match(bus.addr, '0, LOW_ROM_W);

	always_comb begin
		ram = 1'b0;
		if (!low_rom) begin
			// first 4 MB are always there
			if (bus.addr[23:22] == 2'b00)
				ram = 1'b1;
			// 4 to 8 MB
			if ((cfg_mem == MEM_8M || cfg_mem == MEM_14M) && bus.addr[23:22] == 2'b01)
				ram = 1'b1;
			// 8 to 12 MB and 12 to 14 MB
			if (cfg_mem == MEM_14M && (bus.addr[23:22] == 2'b10 || bus.addr[23:21] == 3'b110))
				ram = 1'b1;
		end
	end

	// either tos layout answers, plus the low mirror
	assign tos = low_rom ||
		mem_match(bus.addr, TOS256_BASE, TOS256_W) ||
		mem_match(bus.addr, TOS192_LO_BASE, TOS192_LO_W) ||
		mem_match(bus.addr, TOS192_HI_BASE, TOS192_HI_W);

	assign cart = mem_match(bus.addr, CART_BASE, CART_W);

	// rom and cartridge only answer reads, a write there ends in a bus error
	assign mem_hit = ram || (bus.rw && (tos || cart));

	assign mem_rd = cpu_acc && bus.rw && mem_hit;
	assign mem_wr = cpu_acc && !bus.rw && ram;

	assign io_sel = cpu_acc && (bus.addr[23:16] == IO_PAGE);
	assign io_off = bus.io_offset();

	always_comb begin
		dev_sel = DEV_NONE;
		if (io_sel) begin
			if (io_match(io_off, IO_MMU_BASE, IO_MMU_W))
				dev_sel = DEV_MMU;
			else if (io_match(io_off, IO_VIDEO_BASE, IO_VIDEO_W))
				dev_sel = DEV_VIDEO;
			else if (io_match(io_off, IO_DMA_BASE, IO_DMA_W))
				dev_sel = DEV_DMA;
			else if (io_match(io_off, IO_PSG_BASE, IO_PSG_W))
				dev_sel = DEV_PSG;
			else if (io_match(io_off, IO_ACIA_BASE, IO_ACIA_W))
				dev_sel = DEV_ACIA;
			else if (io_match(io_off, IO_MFP_BASE, IO_MFP_W))
				dev_sel = DEV_MFP;
			// an ste always carries a blitter
			else if ((cfg_blitter || cfg_ste) && io_match(io_off, IO_BLITTER_BASE, IO_BLITTER_W))
				dev_sel = DEV_BLITTER;
			else if (cfg_ste && io_match(io_off, IO_STE_JOY_BASE, IO_STE_JOY_W))
				dev_sel = DEV_STE_JOY;
			else if (cfg_ste && io_match(io_off, IO_STE_SND_BASE, IO_STE_SND_W))
				dev_sel = DEV_STE_SND;
		end
	end

	// another bus master holds the cpu by withholding dtack
	assign dtack = ((cpu_acc && mem_hit) || (dev_sel != DEV_NONE) || iack_dtack) && !br;

endmodule

// File: logic/bus_timeout.sv
// ======================================
// bus error timeout
// raises berr when cpu slots pass without
// dtack, so absent hardware can be probed
// ======================================
module bus_timeout (
	input logic clk_8,
	input logic pll_locked,
	input logic cfg_reset,
	input logic cpu_cycle,
	input logic dtack,
	input logic br,
	input logic clr_berr,
	output logic berr
);
	import st_glue_pkg::*;

	logic cyc_q;
	logic ok_q;
	logic [TIMEOUT_W-1:0] count;

	// sample the slot and its outcome, the counter acts one clock later
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			cyc_q <= 1'b0;
			ok_q <= 1'b0;
		end else begin
			cyc_q <= cpu_cycle;
			// another master on the bus is not a fault of the cpu
			ok_q <= dtack || br;
		end
	end

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			count <= '0;
		end else if (cfg_reset || clr_berr) begin
			count <= '0;
		end else if (cyc_q && (count != TIMEOUT_MAX)) begin
			if (ok_q)
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

	// counter holds at max until the cpu takes the exception
	assign berr = (count == TIMEOUT_MAX);

endmodule

// File: logic/irq_glue.sv
// ======================================
// interrupt glue
// vbi and hbi edge latches, ipl priority
// encoder and interrupt acknowledge
// ======================================
module irq_glue (
	input logic clk_8,
	input logic pll_locked,
	input logic cfg_reset,
	input logic st_hs,
	input logic st_vs,
	input logic mfp_irq,
	cpu_bus_if.irq bus,
	output st_glue_pkg::ipl_t ipl,
	output logic mfp_iack,
	output st_glue_pkg::vector_t auto_vector,
	output logic iack_dtack
);
	import st_glue_pkg::*;

	logic vs_q1;
	logic vs_q2;
	logic hs_q1;
	logic hs_q2;
	logic vbi;
	logic hbi;
	logic iack;
	ipl_t level;
	logic vbi_ack;
	logic hbi_ack;

	// syncs come from the video timing, sample twice for the edge
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			vs_q1 <= 1'b0;
			vs_q2 <= 1'b0;
			hs_q1 <= 1'b0;
			hs_q2 <= 1'b0;
		end else begin
			vs_q1 <= st_vs;
			vs_q2 <= vs_q1;
			hs_q1 <= st_hs;
			hs_q2 <= hs_q1;
		end
	end

	// cpu space cycle, level sits on a3..a1
	assign iack = bus.as && bus.cpu_cycle && (bus.fc == FC_IACK);
	assign level = bus.addr[3:1];

	// acknowledged level is the inverted ipl code
	assign vbi_ack = iack && (level == ~IPL_VBI);
	assign hbi_ack = iack && (level == ~IPL_HBI);
	assign mfp_iack = iack && (level == ~IPL_MFP);

	// pending flags, an acknowledge wins over a new edge
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			vbi <= 1'b0;
			hbi <= 1'b0;
		end else begin
			if (cfg_reset || vbi_ack)
				vbi <= 1'b0;
			else if (vs_q1 && !vs_q2)
				vbi <= 1'b1;
			if (cfg_reset || hbi_ack)
				hbi <= 1'b0;
			else if (hs_q1 && !hs_q2)
				hbi <= 1'b1;
		end
	end

	// mfp above vbi above hbi
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			ipl <= IPL_NONE;
		else if (cfg_reset)
			ipl <= IPL_NONE;
		else if (mfp_irq)
			ipl <= IPL_MFP;
		else if (vbi)
			ipl <= IPL_VBI;
		else if (hbi)
			ipl <= IPL_HBI;
		else
			ipl <= IPL_NONE;
	end

	// the cpu runs vectored only, so the autovectors are served here
	assign auto_vector = vbi_ack ? VEC_VBI : (hbi_ack ? VEC_HBI : 8'h00);

	// mfp delivers its own vector, the glue still ends the cycle
	assign iack_dtack = vbi_ack || hbi_ack || mfp_iack;

endmodule

// File: logic/st_glue.sv
// ======================================
// st glue top level
// slot sequencing, address decoding, bus
// error timeout and interrupt generation
// ======================================
module st_glue (
	input logic clk_8,
	input logic pll_locked,
	input logic cfg_reset,
	input logic cfg_fast_cpu,
	input logic cfg_ste,
	input logic cfg_blitter,
	input st_glue_pkg::mem_size_t cfg_mem,
	input logic cpu_as,
	input st_glue_pkg::st_addr_t cpu_addr,
	input logic cpu_rw,
	input st_glue_pkg::fc_t cpu_fc,
	input logic br,
	input logic clr_berr,
	input logic st_hs,
	input logic st_vs,
	input logic mfp_irq,
	output st_glue_pkg::slot_t bus_cycle,
	output logic video_cycle,
	output logic cpu_cycle,
	output st_glue_pkg::dev_t dev_sel,
	output logic mem_rd,
	output logic mem_wr,
	output logic dtack,
	output logic berr,
	output st_glue_pkg::ipl_t ipl,
	output logic mfp_iack,
	output st_glue_pkg::vector_t auto_vector
);

	// vector fetch ends its cycle through the decoder
	logic iack_dtack;

	cpu_bus_if bus ();

	// latched cpu signals onto the shared bus
	assign bus.as = cpu_as;
	assign bus.addr = cpu_addr;
	assign bus.rw = cpu_rw;
	assign bus.fc = cpu_fc;
	assign cpu_cycle = bus.cpu_cycle;

	bus_slot u_bus_slot (
		.clk_8        (clk_8),
		.pll_locked   (pll_locked),
		.cfg_fast_cpu (cfg_fast_cpu),
		.bus          (bus),
		.bus_cycle    (bus_cycle),
		.video_cycle  (video_cycle)
	);

	addr_decode u_addr_decode (
		.bus         (bus),
		.br          (br),
		.cfg_mem     (cfg_mem),
		.cfg_ste     (cfg_ste),
		.cfg_blitter (cfg_blitter),
		.iack_dtack  (iack_dtack),
		.dev_sel     (dev_sel),
		.mem_rd      (mem_rd),
		.mem_wr      (mem_wr),
		.dtack       (dtack)
	);

	bus_timeout u_bus_timeout (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.cfg_reset  (cfg_reset),
		.cpu_cycle  (bus.cpu_cycle),
		.dtack      (dtack),
		.br         (br),
		.clr_berr   (clr_berr),
		.berr       (berr)
	);

	irq_glue u_irq_glue (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.cfg_reset   (cfg_reset),
		.st_hs       (st_hs),
		.st_vs       (st_vs),
		.mfp_irq     (mfp_irq),
		.bus         (bus),
		.ipl         (ipl),
		.mfp_iack    (mfp_iack),
		.auto_vector (auto_vector),
		.iack_dtack  (iack_dtack)
	);

endmodule

// File: tests/tb_st_glue.sv
// ======================================
// st_glue testbench
// reference model of slots, memory map,
// bus error timeout and interrupts, checked
// every cycle against the DUT
// ======================================
module tb_st_glue;
	import st_glue_pkg::*;

	// rough length of all sequences and twice that as the limit
	localparam int RUN_CYCLES = 1000;
	localparam int MAX_CYCLES = 2 * RUN_CYCLES;

	logic clk_8;
	logic pll_locked;
	logic cfg_reset;
	logic cfg_fast_cpu;
	logic cfg_ste;
	logic cfg_blitter;
	mem_size_t cfg_mem;
	logic cpu_as;
	st_addr_t cpu_addr;
	logic cpu_rw;
	fc_t cpu_fc;
	logic br;
	logic clr_berr;
	logic st_hs;
	logic st_vs;
	logic mfp_irq;
	slot_t bus_cycle;
	logic video_cycle;
	logic cpu_cycle;
	dev_t dev_sel;
	logic mem_rd;
	logic mem_wr;
	logic dtack;
	logic berr;
	ipl_t ipl;
	logic mfp_iack;
	vector_t auto_vector;

	// model state
	slot_t m_slot;
	logic m_cyc_q;
	logic m_ok_q;
	logic [3:0] m_count;
	logic m_vs1;
	logic m_vs2;
	logic m_hs1;
	logic m_hs2;
	logic m_vbi;
	logic m_hbi;
	ipl_t m_ipl;

	// model combinational results
	logic e_cpu;
	logic e_acc;
	logic e_ram;
	logic e_rom;
	logic e_iack;
	logic [2:0] e_lvl;
	logic e_ack_any;
	logic e_dtack;
	dev_t e_dev;
	vector_t e_vec;

	logic [31:0] seed;
	int cycles;

	st_glue dut (.*);

	initial begin
		clk_8 = 1'b0;
		forever #5 clk_8 = ~clk_8;
	end

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic in_range(logic [23:0] a, logic [23:0] lo, logic [23:0] hi);
		return (a >= lo) && (a <= hi);
	endfunction

	// ram windows per installed size where the first 8 bytes belong to rom
	function automatic logic ram_area(st_addr_t a, mem_size_t m);
		if (a < 24'h8)
			return 1'b0;
		if (a < 24'h400000)
			return 1'b1;
		if (a < 24'h800000)
			return (m == MEM_8M) || (m == MEM_14M);
		if (a < 24'he00000)
			return m == MEM_14M;
		return 1'b0;
	endfunction

	// tos 256k, cartridge, tos 192k and the low vector mirror
	function automatic logic rom_area(st_addr_t a);
		return (a < 24'h8) || in_range(a, 24'he00000, 24'he3ffff) ||
			in_range(a, 24'hfa0000, 24'hfeffff);
	endfunction

	function automatic dev_t io_device(st_addr_t a, logic ste, logic blit);
		if (a[23:16] != 8'hff)
			return DEV_NONE;
		if (in_range(a, 24'hff8000, 24'hff8001))
			return DEV_MMU;
		if (in_range(a, 24'hff8200, 24'hff827f))
			return DEV_VIDEO;
		if (in_range(a, 24'hff8600, 24'hff860f))
			return DEV_DMA;
		if (in_range(a, 24'hff8800, 24'hff88ff))
			return DEV_PSG;
		if (in_range(a, 24'hfffc00, 24'hfffcff))
			return DEV_ACIA;
		if (in_range(a, 24'hfffa00, 24'hfffa3f))
			return DEV_MFP;
		if ((ste || blit) && in_range(a, 24'hff8a00, 24'hff8aff))
			return DEV_BLITTER;
		if (ste && in_range(a, 24'hff9200, 24'hff923f))
			return DEV_STE_JOY;
		if (ste && in_range(a, 24'hff8900, 24'hff893f))
			return DEV_STE_SND;
		return DEV_NONE;
	endfunction

	// upper address bytes that land near the io windows
	function automatic logic [7:0] io_high_byte(logic [3:0] k);
		logic [7:0] t [16];
		t = '{8'h80, 8'h82, 8'h86, 8'h88, 8'h89, 8'h8a, 8'h92, 8'hfa,
			8'hfc, 8'h84, 8'h81, 8'h83, 8'h8b, 8'h93, 8'hfb, 8'h00};
		return t[k];
	endfunction

	// top bytes at the edges of ram, rom and cartridge areas
	function automatic logic [7:0] page_byte(logic [3:0] k);
		logic [7:0] t [16];
		t = '{8'h00, 8'h3f, 8'h40, 8'h7f, 8'h80, 8'hbf, 8'hc0, 8'hdf,
			8'he0, 8'he4, 8'hfa, 8'hfb, 8'hfc, 8'hfe, 8'hff, 8'hf0};
		return t[k];
	endfunction

	task automatic abort_run();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_8);
		#1;
	endtask

	task automatic wait_cpu_slot();
		next_cycle();
		while (!cpu_cycle)
			next_cycle();
	endtask

	// one acknowledge cycle with the level on a3..a1
	task automatic ack_level(input logic [2:0] lvl, input logic [7:0] vec, input logic mfp);
		wait_cpu_slot();
		cpu_as = 1'b1;
		cpu_rw = 1'b1;
		cpu_fc = 3'd7;
		cpu_addr = {20'hfffff, lvl, 1'b0};
		@(negedge clk_8);
		check_value("dtack", dtack, 1'b1);
		check_value("mfp_iack", mfp_iack, mfp);
		if (!mfp)
			check_value("auto_vector", auto_vector, vec);
		next_cycle();
		cpu_as = 1'b0;
		cpu_fc = 3'd0;
	endtask

	// model of the combinational outputs
	always_comb begin
		e_cpu = (m_slot == 2'd1) || (cfg_fast_cpu && m_slot == 2'd3);
		e_acc = e_cpu && cpu_as;
		e_ram = ram_area(cpu_addr, cfg_mem);
		e_rom = rom_area(cpu_addr);
		e_iack = cpu_as && e_cpu && (cpu_fc == 3'd7);
		e_lvl = cpu_addr[3:1];
		e_ack_any = e_iack && (e_lvl == 3'd6 || e_lvl == 3'd4 || e_lvl == 3'd2);
		e_dev = e_acc ? io_device(cpu_addr, cfg_ste, cfg_blitter) : DEV_NONE;
		e_vec = 8'h00;
		if (e_iack && e_lvl == 3'd4)
			e_vec = 8'h1c;
		else if (e_iack && e_lvl == 3'd2)
			e_vec = 8'h1a;
		e_dtack = !br && ((e_acc && (e_ram || (cpu_rw && e_rom))) ||
			(e_dev != DEV_NONE) || e_ack_any);
	end

	// model of the registered state
	always @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			m_slot <= 2'd0;
			m_cyc_q <= 1'b0;
			m_ok_q <= 1'b0;
			m_count <= 4'd0;
			{m_vs1, m_vs2, m_hs1, m_hs2, m_vbi, m_hbi} <= 6'b0;
			m_ipl <= 3'd7;
		end else begin
			m_slot <= m_slot + 2'd1;
			m_cyc_q <= e_cpu;
			m_ok_q <= e_dtack || br;
			// saturated count holds until cleared
			if (cfg_reset || clr_berr)
				m_count <= 4'd0;
			else if (m_cyc_q && m_count != 4'd15)
				m_count <= m_ok_q ? 4'd0 : m_count + 4'd1;
			m_vs1 <= st_vs;
			m_vs2 <= m_vs1;
			m_hs1 <= st_hs;
			m_hs2 <= m_hs1;
			if (cfg_reset || (e_iack && e_lvl == 3'd4))
				m_vbi <= 1'b0;
			else if (m_vs1 && !m_vs2)
				m_vbi <= 1'b1;
			if (cfg_reset || (e_iack && e_lvl == 3'd2))
				m_hbi <= 1'b0;
			else if (m_hs1 && !m_hs2)
				m_hbi <= 1'b1;
			if (cfg_reset || !(mfp_irq || m_vbi || m_hbi))
				m_ipl <= 3'd7;
			else
				m_ipl <= mfp_irq ? 3'd1 : (m_vbi ? 3'd3 : 3'd5);
		end
	end

	// outputs settle well before the falling edge
	always @(negedge clk_8) begin
		check_value("bus_cycle", bus_cycle, m_slot);
		check_value("video_cycle", video_cycle, m_slot == 2'd0);
		check_value("cpu_cycle", cpu_cycle, e_cpu);
		check_value("dev_sel", dev_sel, e_dev);
		check_value("mem_rd", mem_rd, e_acc && cpu_rw && (e_ram || e_rom));
		check_value("mem_wr", mem_wr, e_acc && !cpu_rw && e_ram);
		check_value("dtack", dtack, e_dtack);
		check_value("berr", berr, m_count == 4'd15);
		check_value("ipl", ipl, m_ipl);
		check_value("mfp_iack", mfp_iack, e_iack && e_lvl == 3'd6);
		check_value("auto_vector", auto_vector, e_vec);
	end

	always @(posedge clk_8) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, run still busy after %0d cycles", MAX_CYCLES);
			abort_run();
		end
	end

	initial begin
		logic [31:0] r;
		logic [7:0] m8;
		logic [2:0] combo;
		int n;
		int i;
		logic seen;
		seed = 32'h9836_96a9;
		cycles = 0;
		pll_locked = 1'b0;
		{cfg_reset, cfg_fast_cpu, cfg_ste, cfg_blitter} = 4'b0;
		cfg_mem = MEM_4M;
		cpu_as = 1'b0;
		cpu_addr = '0;
		cpu_rw = 1'b1;
		cpu_fc = 3'd0;
		{br, clr_berr, st_hs, st_vs, mfp_irq} = 5'b0;
		repeat (3) @(posedge clk_8);
		#1;
		pll_locked = 1'b1;

		// one cpu slot in four without fast mode and two with it
		for (i = 0; i < 2; i++) begin
			next_cycle();
			cfg_fast_cpu = i[0];
			n = 0;
			repeat (8) begin
				@(negedge clk_8);
				if (cpu_cycle)
					n++;
			end
			check_value("cpu slots in 8 cycles", n, i[0] ? 4 : 2);
		end
		next_cycle();

		// random decode against the memory map
		for (i = 0; i < 300; i++) begin
			r = next_random();
			case (r[1:0])
				2'd0: cpu_addr = r[31:8];
				2'd1: cpu_addr = {8'hff, io_high_byte(r[11:8]), r[23:16]};
				2'd2: cpu_addr = {page_byte(r[11:8]), r[31:16]};
				default: cpu_addr = {20'h0, r[7:4]};
			endcase
			r = next_random();
			cpu_as = r[0] | r[1];
			cpu_rw = r[2];
			cpu_fc = r[5:3];
			br = r[6] & r[7];
			clr_berr = (r[10:8] == 3'd0);
			cfg_fast_cpu = r[11];
			cfg_ste = r[12];
			cfg_blitter = r[13];
			m8 = r[23:16] % 8'd6;
			cfg_mem = mem_size_t'(m8[2:0]);
			next_cycle();
		end

		// write to the rom page gets no dtack
		cfg_fast_cpu = 1'b0;
		br = 1'b0;
		cpu_as = 1'b1;
		cpu_rw = 1'b0;
		cpu_fc = 3'd5;
		cpu_addr = 24'hfe1000;
		clr_berr = 1'b1;
		next_cycle();
		// release the clear once the idle slot has been sampled
		while (bus_cycle != 2'd3)
			next_cycle();
		clr_berr = 1'b0;
		n = 0;
		seen = 1'b0;
		while (!seen) begin
			@(negedge clk_8);
			if (berr)
				seen = 1'b1;
			else if (cpu_cycle)
				n++;
		end
		check_value("cpu slots before berr", n, 15);
		repeat (10) begin
			next_cycle();
			check_value("berr", berr, 1'b1);
		end
		clr_berr = 1'b1;
		next_cycle();
		clr_berr = 1'b0;
		cpu_as = 1'b0;
		cpu_rw = 1'b1;
		@(negedge clk_8);
		check_value("berr", berr, 1'b0);
		next_cycle();

		// each mix of mfp, vbi and hbi edges
		for (i = 1; i < 8; i++) begin
			combo = i[2:0];
			mfp_irq = combo[2];
			st_vs = combo[1];
			st_hs = combo[0];
			repeat (3) next_cycle();
			@(negedge clk_8);
			check_value("ipl", ipl, combo[2] ? 3'd1 : (combo[1] ? 3'd3 : 3'd5));
			next_cycle();
			{mfp_irq, st_vs, st_hs} = 3'b0;
			cfg_reset = 1'b1;
			next_cycle();
			cfg_reset = 1'b0;
			repeat (2) next_cycle();
		end

		// all three pending and acknowledged from the top
		{mfp_irq, st_vs, st_hs} = 3'b111;
		repeat (4) next_cycle();
		check_value("ipl", ipl, 3'd1);
		st_vs = 1'b0;
		st_hs = 1'b0;
		ack_level(3'd6, 8'h00, 1'b1);
		// mfp drops its request once served
		mfp_irq = 1'b0;
		next_cycle();
		@(negedge clk_8);
		check_value("ipl", ipl, 3'd3);
		ack_level(3'd4, 8'h1c, 1'b0);
		next_cycle();
		@(negedge clk_8);
		check_value("ipl", ipl, 3'd5);
		ack_level(3'd2, 8'h1a, 1'b0);
		next_cycle();
		@(negedge clk_8);
		check_value("ipl", ipl, 3'd7);

		repeat (4) next_cycle();
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: sim.f
+incdir+include
logic/st_glue_pkg.sv
logic/cpu_bus_if.sv
logic/bus_slot.sv
logic/addr_decode.sv
logic/bus_timeout.sv
logic/irq_glue.sv
logic/st_glue.sv
tests/tb_st_glue.sv
